// File: ecc_apb_front.sv
//////////////////////////////
// APB slave of the scratch memory
// data region encodes, injects and issues write or read requests
// register region holds injection masks and error counters
// writes and register access have no wait state
// and data reads have one
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module ecc_apb_front (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  ecc_mem_pkg::apb_addr_u paddr,
   input  logic [`ECC_DATA_W-1:0] pwdata,
   input  logic                   rd_valid,
   input  logic [`ECC_DATA_W-1:0] rd_data,
   input  logic                   single_err,
   input  logic                   double_err,
   output ecc_mem_pkg::mem_wr_t   wr_req,
   output ecc_mem_pkg::mem_rd_t   rd_req,
   output logic [`ECC_DATA_W-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr
);
   import ecc_mem_pkg::*;

   logic                    access;
   logic                    is_csr;
   logic                    csr_ok;
   logic                    csr_wr;
   logic [`ECC_CHECK_W-1:0] enc_check;
   logic [`ECC_DATA_W-1:0]  inj_data;
   logic [`ECC_CHECK_W-1:0] inj_check;
   logic [`ECC_CNT_W-1:0]   err_cnt [2];   // index 0 single and 1 double
   logic [1:0]              cnt_inc;
   logic [1:0]              cnt_clr;

   assign access = psel & penable;
   assign is_csr = paddr.csr.region;
   assign csr_ok = (paddr.csr.pad == '0);
   assign csr_wr = access & is_csr & csr_ok & pwrite;

   secded_encode u_enc (
      .data  (pwdata),
      .check (enc_check)
   );

   // masks corrupt the codeword after clean encoding
   assign wr_req.valid          = access & ~is_csr & pwrite;
   assign wr_req.bank           = paddr.mem.bank;
   assign wr_req.word           = paddr.mem.word;
   assign wr_req.codeword.data  = pwdata ^ inj_data;
   assign wr_req.codeword.check = enc_check ^ inj_check;

   // issue only in the first access cycle
   assign rd_req.valid = access & ~is_csr & ~pwrite & ~rd_valid;
   assign rd_req.bank  = paddr.mem.bank;
   assign rd_req.word  = paddr.mem.word;

   assign pready  = access & (pwrite | is_csr | rd_valid);
   assign pslverr = access & ((is_csr & ~csr_ok) | (~is_csr & ~pwrite & double_err));

   assign cnt_inc = {double_err, single_err};
   assign cnt_clr = {csr_wr & (paddr.csr.index == CSR_DOUBLE_CNT),
                     csr_wr & (paddr.csr.index == CSR_SINGLE_CNT)};

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         inj_data  <= '0;
         inj_check <= '0;
         for (int i = 0; i < 2; i++) begin
            err_cnt[i] <= '0;
         end
      end else begin
         if (csr_wr && paddr.csr.index == CSR_INJ_DATA) inj_data <= pwdata;
         if (csr_wr && paddr.csr.index == CSR_INJ_CHECK) begin
            inj_check <= pwdata[`ECC_CHECK_W-1:0];
         end
         for (int i = 0; i < 2; i++) begin
            if (cnt_clr[i]) err_cnt[i] <= '0;
            else if (cnt_inc[i] && !(&err_cnt[i])) err_cnt[i] <= err_cnt[i] + 1'b1;   // saturate
         end
      end
   end

   always_comb begin
      prdata = '0;
      if (!is_csr) begin
         prdata = rd_data;
      end else if (csr_ok) begin
         case (paddr.csr.index)
            CSR_INJ_DATA:   prdata = inj_data;
            CSR_INJ_CHECK:  prdata = `ECC_DATA_W'(inj_check);
            CSR_SINGLE_CNT: prdata = `ECC_DATA_W'(err_cnt[0]);
            CSR_DOUBLE_CNT: prdata = `ECC_DATA_W'(err_cnt[1]);
            default:        prdata = '0;
         endcase
      end
   end

   a_penable_needs_psel : assert property (@(posedge clk) disable iff (!rst_l)
      penable |-> psel)
      else $error("penable high without psel");

endmodule

`default_nettype wire

// File: ecc_bank.sv
//////////////////////////////
// one bank of codeword storage
// writes when the request names this bank,
// every valid read request loads the read register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module ecc_bank #(
   parameter ecc_mem_pkg::bank_t BANK_ID = '0
) (
   input  logic                   clk,
   input  logic                   rst_l,
   input  ecc_mem_pkg::mem_wr_t   wr_req,
   input  ecc_mem_pkg::mem_rd_t   rd_req,
   output ecc_mem_pkg::codeword_t rd_codeword
);
   import ecc_mem_pkg::*;

   codeword_t mem [`ECC_MEM_WORDS];
   logic      wr_hit;

   assign wr_hit = wr_req.valid & (wr_req.bank == BANK_ID);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < `ECC_MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
         rd_codeword <= '0;
      end else begin
         if (wr_hit) mem[wr_req.word] <= wr_req.codeword;
         if (rd_req.valid) rd_codeword <= mem[rd_req.word];   // read path picks the bank
      end
   end

   // front end never issues both to one word, so no bypass is needed
   a_no_wr_rd_same_word : assert property (@(posedge clk) disable iff (!rst_l)
      !(wr_hit && rd_req.valid && (rd_req.bank == BANK_ID) && (rd_req.word == wr_req.word)))
      else $error("bank %0d write and read to word %0d in one cycle", BANK_ID, wr_req.word);

endmodule

`default_nettype wire

// File: ecc_mem.f
+incdir+.
ecc_mem_pkg.sv
secded_encode.sv
secded_decode.sv
ecc_bank.sv
ecc_read_path.sv
ecc_apb_front.sv
ecc_mem_top.sv
tb_ecc_mem.sv

// File: ecc_mem_defs.svh
//////////////////////////////
// sizing macros for the SECDED scratch memory
// include wherever a width or depth is needed
//////////////////////////////

`ifndef ECC_MEM_DEFS_SVH
`define ECC_MEM_DEFS_SVH

// memory geometry
`define ECC_MEM_BANKS 4
`define ECC_MEM_WORDS 16

// codeword layout
`define ECC_DATA_W    32
`define ECC_CHECK_W   7   // six hamming bits + overall parity

// APB address width, byte address
`define ECC_ADDR_W    12

// error counters saturate at all ones
`define ECC_CNT_W     16

`endif

// File: ecc_mem_pkg.sv
//////////////////////////////
// shared types for the SECDED scratch memory
// request structs, the stored codeword and the
// two views of the APB address
//////////////////////////////

`default_nettype none

`include "ecc_mem_defs.svh"

package ecc_mem_pkg;

   typedef logic [$clog2(`ECC_MEM_BANKS)-1:0] bank_t;
   typedef logic [$clog2(`ECC_MEM_WORDS)-1:0] word_t;

   typedef struct packed {
      logic [`ECC_CHECK_W-1:0] check;
      logic [`ECC_DATA_W-1:0]  data;
   } codeword_t;

   typedef struct packed {
      logic      valid;
      bank_t     bank;
      word_t     word;
      codeword_t codeword;
   } mem_wr_t;

   typedef struct packed {
      logic  valid;
      bank_t bank;
      word_t word;
   } mem_rd_t;

   typedef enum logic [1:0] {
      CSR_INJ_DATA   = 2'd0,
      CSR_INJ_CHECK  = 2'd1,
      CSR_SINGLE_CNT = 2'd2,
      CSR_DOUBLE_CNT = 2'd3
   } csr_idx_e;

   // region 0 is data
   typedef struct packed {
      logic                                                 region;
      logic [`ECC_ADDR_W-$bits(bank_t)-$bits(word_t)-4:0]   pad;
      bank_t                                                bank;
      word_t                                                word;
      logic [1:0]                                           byte_sel;
   } mem_addr_t;

   // region 1 is registers, nonzero pad is an undefined register
   typedef struct packed {
      logic                                    region;
      logic [`ECC_ADDR_W-$bits(csr_idx_e)-4:0] pad;
      csr_idx_e                                index;
      logic [1:0]                              byte_sel;
   } csr_addr_t;

   typedef union packed {
      mem_addr_t mem;
      csr_addr_t csr;
   } apb_addr_u;

endpackage

`default_nettype wire

// File: ecc_mem_top.sv
//////////////////////////////
// SECDED scratch memory on APB3
// front end, four codeword banks and
// the decoding read path
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module ecc_mem_top (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  ecc_mem_pkg::apb_addr_u paddr,
   input  logic [`ECC_DATA_W-1:0] pwdata,
   output logic [`ECC_DATA_W-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr
);
   import ecc_mem_pkg::*;

   mem_wr_t                wr_req;
   mem_rd_t                rd_req;
   codeword_t              rd_codeword [`ECC_MEM_BANKS];
   logic                   rd_valid;
   logic [`ECC_DATA_W-1:0] rd_data;
   logic                   single_err;
   logic                   double_err;

   ecc_apb_front u_front (
      .clk        (clk),
      .rst_l      (rst_l),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .single_err (single_err),
      .double_err (double_err),
      .wr_req     (wr_req),
      .rd_req     (rd_req),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr)
   );

   for (genvar b = 0; b < `ECC_MEM_BANKS; b++) begin : g_bank
      ecc_bank #(
         .BANK_ID (bank_t'(b))
      ) u_bank (
         .clk         (clk),
         .rst_l       (rst_l),
         .wr_req      (wr_req),
         .rd_req      (rd_req),
         .rd_codeword (rd_codeword[b])
      );
   end

   ecc_read_path u_rd (
      .clk         (clk),
      .rst_l       (rst_l),
      .rd_req      (rd_req),
      .rd_codeword (rd_codeword),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .single_err  (single_err),
      .double_err  (double_err)
   );

endmodule

`default_nettype wire

// File: ecc_read_path.sv
//////////////////////////////
// read side of the scratch memory
// picks the bank read one cycle earlier,
// decodes it and reports errors with rd_valid
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module ecc_read_path (
   input  logic                    clk,
   input  logic                    rst_l,
   input  ecc_mem_pkg::mem_rd_t    rd_req,
   input  ecc_mem_pkg::codeword_t  rd_codeword [`ECC_MEM_BANKS],
   output logic                    rd_valid,
   output logic [`ECC_DATA_W-1:0]  rd_data,
   output logic                    single_err,
   output logic                    double_err
);
   import ecc_mem_pkg::*;

   bank_t bank_q;
   logic  dec_single;
   logic  dec_double;

   // banks register the word on the same edge
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid <= 1'b0;
         bank_q   <= '0;
      end else begin
         rd_valid <= rd_req.valid;
         if (rd_req.valid) bank_q <= rd_req.bank;
      end
   end

   secded_decode u_dec (
      .codeword   (rd_codeword[bank_q]),
      .data       (rd_data),
      .single_err (dec_single),
      .double_err (dec_double)
   );

   assign single_err = rd_valid & dec_single;   // idle banks hold stale words
   assign double_err = rd_valid & dec_double;

   a_err_exclusive : assert property (@(posedge clk) disable iff (!rst_l)
      !(single_err && double_err))
      else $error("single and double error together on bank %0d", bank_q);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ecc_mem -Mdir obj_dir -f ecc_mem.f \
   && ./obj_dir/Vtb_ecc_mem > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* PASSED \*\*\*' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: secded_decode.sv
//////////////////////////////
// SECDED check of one stored codeword
// corrects a single flipped bit, flags
// single and double errors, purely combinational
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module secded_decode (
   input  ecc_mem_pkg::codeword_t  codeword,
   output logic [`ECC_DATA_W-1:0]  data,
   output logic                    single_err,
   output logic                    double_err
);

   logic [`ECC_CHECK_W-1:0] calc_check;
   logic [`ECC_CHECK_W-1:0] diff;
   logic [5:0]              syndrome;
   logic                    par_err;
   logic [37:0]             hv;       // positions 1..38, hamming order
   logic [37:0]             flip;
   logic [37:0]             hv_fix;

   // recompute check bits from the stored data
   secded_encode u_enc (
      .data  (codeword.data),
      .check (calc_check)
   );

   assign diff     = calc_check ^ codeword.check;
   assign syndrome = diff[5:0];
   assign par_err  = ^diff;           // odd number of flipped bits

   // odd count is treated as one error, this includes parity bit alone
   assign single_err = par_err;
   assign double_err = (syndrome != 6'd0) & ~par_err;

   // interleave check bits at the power of two positions
   assign hv = {codeword.data[31:26], codeword.check[5],
                codeword.data[25:11], codeword.check[4],
                codeword.data[10:4],  codeword.check[3],
                codeword.data[3:1],   codeword.check[2],
                codeword.data[0],     codeword.check[1:0]};

   for (genvar i = 0; i < 38; i++) begin : g_flip
      assign flip[i] = (syndrome == 6'(i + 1));
   end

   assign hv_fix = single_err ? (hv ^ flip) : hv;

   // a hit on a check position leaves the data alone
   assign data = {hv_fix[37:32], hv_fix[30:16], hv_fix[14:8], hv_fix[6:4], hv_fix[2]};

endmodule

`default_nettype wire

// File: secded_encode.sv
//////////////////////////////
// hamming check bits of a 32-bit word
// six parity groups plus one overall parity bit
// combinational, used by the write path and the decoder
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module secded_encode (
   input  logic [`ECC_DATA_W-1:0]  data,
   output logic [`ECC_CHECK_W-1:0] check
);

   // data bits covered by each hamming bit
   // bit k of a group is set when the codeword position of data[k] has that bit set
   localparam logic [`ECC_DATA_W-1:0] HAM_MASK [6] = '{
      32'h56AA_AD5B,   // position bit 0
      32'h9B33_366D,   // position bit 1
      32'hE3C3_C78E,   // position bit 2
      32'h03FC_07F0,   // position bit 3
      32'h03FF_F800,   // position bit 4
      32'hFC00_0000    // position bit 5
   };

   logic [5:0] ham;

   always_comb begin
      for (int i = 0; i < 6; i++) begin
         ham[i] = ^(data & HAM_MASK[i]);
      end
   end

   // top bit makes the parity over all 39 bits even
   assign check = {(^data) ^ (^ham), ham};

endmodule

`default_nettype wire

// File: tb_ecc_mem.sv
//////////////////////////////
// testbench for the SECDED scratch memory
// random APB traffic from an LFSR, checked against a
// word model that keeps the injection masks of each write
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defs.svh"

module tb_ecc_mem;
   import ecc_mem_pkg::*;

   localparam int HALF    = 50;
   localparam int N_WORDS = `ECC_MEM_BANKS * `ECC_MEM_WORDS;
   localparam int N_ERR   = 16;   // injected writes per error kind
   // fill and read back plus two error passes of 6 transfers and the register tests
   localparam int N_XFERS = 2 * N_WORDS + 12 * N_ERR + 18;
   localparam logic [11:0] CSR_BASE = 12'h800;

   logic                   clk;
   logic                   rst_l;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`ECC_ADDR_W-1:0] paddr;
   logic [`ECC_DATA_W-1:0] pwdata;
   logic [`ECC_DATA_W-1:0] prdata;
   logic                   pready;
   logic                   pslverr;

   logic [31:0]            lfsr;
   int                     checks;
   int                     errors;
   int                     exp_single;
   int                     exp_double;
   logic [`ECC_DATA_W-1:0] m_data [N_WORDS];   // clean data per word
   logic [38:0]            m_mask [N_WORDS];   // {check, data} masks in force at write
   logic [38:0]            inj;                // masks currently held by the DUT
   logic [31:0]            v;
   logic [31:0]            c;

   ecc_mem_top dut0 (
      .clk     (clk),
      .rst_l   (rst_l),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #HALF clk = ~clk;

   // fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // setup then access phase starting on a falling edge
   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           input int exp_waits, output logic [31:0] rdata, output logic err);
      int cycles;
      cycles  = 0;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;   // outputs settle well before the rising edge
      while (!pready) begin
         cycles++;
         @(negedge clk);
         #1;
      end
      rdata = prdata;
      err   = pslverr;
      compare("wait_states", exp_waits, cycles);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic csr_write(input logic [1:0] idx, input logic [31:0] val);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, CSR_BASE | {8'h0, idx, 2'b00}, val, 0, rd, err);
      compare("csr_write_pslverr", 32'd0, 32'(err));
   endtask

   task automatic csr_read(input logic [1:0] idx, input logic [31:0] exp, input string name);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, CSR_BASE | {8'h0, idx, 2'b00}, 32'd0, 0, rd, err);
      compare(name, exp, rd);
      compare({name, "_pslverr"}, 32'd0, 32'(err));
   endtask

   task automatic mem_write(input int idx, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, {4'h0, idx[5:0], 2'b00}, data, 0, rd, err);   // bank is idx[5:4]
      compare("mem_write_pslverr", 32'd0, 32'(err));
      m_data[idx] = data;
      m_mask[idx] = inj;
   endtask

   // one flipped bit is corrected and two are only reported
   task automatic mem_read_check(input int idx, input string name);
      logic [31:0] rd;
      logic        err;
      int          flips;
      apb_xfer(1'b0, {4'h0, idx[5:0], 2'b00}, 32'd0, 1, rd, err);
      flips = $countones(m_mask[idx]);
      if (flips < 2) begin
         compare(name, m_data[idx], rd);
         compare({name, "_pslverr"}, 32'd0, 32'(err));
         if (flips == 1) exp_single++;
      end else begin
         compare({name, "_pslverr"}, 32'd1, 32'(err));
         exp_double++;
      end
   endtask

   // positions 0..31 land in inj_data and 32..38 in inj_check
   task automatic error_round(input int nflips, input string name);
      int a;
      int b;
      int idx;
      a = rand_bits(6) % 39;
      b = a;
      while (nflips == 2 && b == a) begin
         b = rand_bits(6) % 39;
      end
      inj    = '0;
      inj[a] = 1'b1;
      inj[b] = 1'b1;
      csr_write(CSR_INJ_DATA, inj[31:0]);
      csr_write(CSR_INJ_CHECK, {25'h0, inj[38:32]});
      idx = rand_bits(6);
      mem_write(idx, rand_bits(32));
      mem_read_check(idx, name);
      csr_read(CSR_SINGLE_CNT, exp_single, {name, "_single_cnt"});
      csr_read(CSR_DOUBLE_CNT, exp_double, {name, "_double_cnt"});
   endtask

   task automatic undef_access(input logic wr, input logic [1:0] idx, input logic [31:0] val);
      logic [31:0] pad;
      logic [31:0] rd;
      logic        err;
      pad = rand_bits(7) | 32'h1;   // nonzero pad means no such register
      apb_xfer(wr, {1'b1, pad[6:0], idx, 2'b00}, val, 0, rd, err);
      if (!wr) compare("undef_rdata", 32'd0, rd);
      compare("undef_pslverr", 32'd1, 32'(err));
   endtask

   initial begin
      clk        = 1'b0;
      rst_l      = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      lfsr       = 32'h969d_a730;
      checks     = 0;
      errors     = 0;
      exp_single = 0;
      exp_double = 0;
      inj        = '0;
      repeat (5) @(negedge clk);
      rst_l = 1'b1;
      @(negedge clk);

      // clean fill of every bank and word
      for (int i = 0; i < N_WORDS; i++) begin
         mem_write(i, rand_bits(32));
      end
      for (int i = 0; i < N_WORDS; i++) begin
         mem_read_check(i, "fill_read");
      end

      for (int i = 0; i < N_ERR; i++) begin
         error_round(1, "single_read");
      end
      for (int i = 0; i < N_ERR; i++) begin
         error_round(2, "double_read");
      end

      // undefined index leaves counters and masks alone
      undef_access(1'b0, CSR_SINGLE_CNT, 32'd0);
      undef_access(1'b1, CSR_SINGLE_CNT, 32'd0);
      undef_access(1'b1, CSR_INJ_DATA, 32'hffff_ffff);
      csr_read(CSR_INJ_DATA, inj[31:0], "undef_inj_data");
      csr_read(CSR_INJ_CHECK, {25'h0, inj[38:32]}, "undef_inj_check");
      csr_read(CSR_SINGLE_CNT, exp_single, "undef_single_cnt");
      csr_read(CSR_DOUBLE_CNT, exp_double, "undef_double_cnt");

      // each clear touches only its own counter
      csr_write(CSR_SINGLE_CNT, 32'd0);
      exp_single = 0;
      csr_read(CSR_SINGLE_CNT, 32'd0, "clear_single_cnt");
      csr_read(CSR_DOUBLE_CNT, exp_double, "clear_keeps_double_cnt");
      csr_write(CSR_DOUBLE_CNT, 32'd0);
      exp_double = 0;
      csr_read(CSR_DOUBLE_CNT, 32'd0, "clear_double_cnt");
      v = rand_bits(32);
      c = rand_bits(7);
      csr_write(CSR_INJ_DATA, v);
      csr_write(CSR_INJ_CHECK, c);
      csr_read(CSR_INJ_DATA, v, "inj_data_readback");
      csr_read(CSR_INJ_CHECK, c, "inj_check_readback");
      inj = '0;
      csr_write(CSR_INJ_DATA, 32'd0);
      csr_write(CSR_INJ_CHECK, 32'd0);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // each transfer gets 20 cycles plus the reset
   initial begin
      #((N_XFERS * 20 + 5) * 2 * HALF);
      $display("timeout, the tests did not finish within %0d transfers of 20 cycles", N_XFERS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
